/* include/vcache_settings.svh */
`ifndef VCACHE_SETTINGS_SVH
`define VCACHE_SETTINGS_SVH

// buffer depth and slot index width
`define VIC_SIZE      4
`define VIC_IDX_BITS  2

// probe ports, fill/evict ports
// WR_PORTS must not exceed VIC_SIZE
`define RD_PORTS      2
`define WR_PORTS      2

// address split and line payload
`define SET_BITS      5
`define TAG_BITS      8
`define LINE_BITS     64

`endif

/* src/vcache_pkg.sv */
`include "vcache_settings.svh"

package vcache_pkg;

    // slot number and occupancy count (count needs one extra bit for a full buffer)
    typedef logic [`VIC_IDX_BITS-1:0] vic_idx_t;
    typedef logic [`VIC_IDX_BITS:0]   vic_cnt_t;

    typedef struct packed {
        logic                  valid;
        logic [`TAG_BITS-1:0]  tag;
        logic [`LINE_BITS-1:0] data;
    } vic_line_t;

    // line plus the set it was evicted from
    typedef struct packed {
        vic_line_t            line;
        logic [`SET_BITS-1:0] set_idx;
    } vic_entry_t;

    typedef struct packed {
        logic                 en;
        logic [`SET_BITS-1:0] set_idx;
        logic [`TAG_BITS-1:0] tag;
    } vic_probe_t;

    typedef struct packed {
        logic                 valid;
        logic [`SET_BITS-1:0] set_idx;
        vic_line_t            line;
    } vic_fill_t;

    // slots is one-hot or zero, slot is its encoded form
    typedef struct packed {
        logic [`VIC_SIZE-1:0] slots;
        vic_idx_t             slot;
        logic                 hit;
    } vic_hit_t;

endpackage

/* src/victim_lookup.sv */
`timescale 1ns/10ps

`include "vcache_settings.svh"

module victim_lookup (
    input  vcache_pkg::vic_entry_t [`VIC_SIZE-1:0] entries,
    input  vcache_pkg::vic_probe_t [`RD_PORTS-1:0] probes,
    output vcache_pkg::vic_hit_t   [`RD_PORTS-1:0] hits
);

    // match[p][s] set when probe p finds its key in slot s
    logic [`RD_PORTS-1:0][`VIC_SIZE-1:0] match;

    always_comb begin
        for (int p = 0; p < `RD_PORTS; p++) begin
            for (int s = 0; s < `VIC_SIZE; s++) begin
                match[p][s] = probes[p].en
                           && entries[s].line.valid
                           && (entries[s].line.tag == probes[p].tag)
                           && (entries[s].set_idx == probes[p].set_idx);
            end
        end
    end

    // lowest index wins, scan from the top so the last write is the lowest
    always_comb begin
        for (int p = 0; p < `RD_PORTS; p++) begin
            hits[p] = '0;
            for (int s = `VIC_SIZE - 1; s >= 0; s--) begin
                if (match[p][s]) begin
                    hits[p].slot = vcache_pkg::vic_idx_t'(s);
                    hits[p].hit  = 1'b1;
                end
            end
            hits[p].slots[hits[p].slot] = hits[p].hit;
        end
    end

endmodule

/* src/victim_queue.sv */
`timescale 1ns/10ps

`include "vcache_settings.svh"

module victim_queue (
    input  logic                                   clock,
    input  logic                                   reset,
    input  vcache_pkg::vic_hit_t   [`RD_PORTS-1:0] hits,
    input  vcache_pkg::vic_fill_t  [`WR_PORTS-1:0] fills,
    output vcache_pkg::vic_entry_t [`VIC_SIZE-1:0] entries,
    output vcache_pkg::vic_entry_t [`RD_PORTS-1:0] read_entry,
    output logic                   [`RD_PORTS-1:0] read_valid,
    output vcache_pkg::vic_entry_t [`WR_PORTS-1:0] evict_entry,
    output logic                   [`WR_PORTS-1:0] evict_valid
);

    // slot 0 holds the oldest line
    vcache_pkg::vic_entry_t [`VIC_SIZE-1:0] entries_q;
    vcache_pkg::vic_entry_t [`VIC_SIZE-1:0] entries_d;
    vcache_pkg::vic_cnt_t                   tail_q;
    vcache_pkg::vic_cnt_t                   tail_d;

    logic [`VIC_SIZE-1:0]                   remove_mask;
    vcache_pkg::vic_entry_t [`VIC_SIZE-1:0] survivors;
    vcache_pkg::vic_cnt_t                   surv_cnt;
    vcache_pkg::vic_cnt_t                   fill_cnt;
    vcache_pkg::vic_cnt_t                   free_cnt;
    vcache_pkg::vic_cnt_t                   evict_cnt;
    vcache_pkg::vic_cnt_t                   keep_cnt;

    assign entries = entries_q;

    // a slot hit by two probes is still removed once
    always_comb begin
        remove_mask = '0;
        for (int p = 0; p < `RD_PORTS; p++) begin
            remove_mask = remove_mask | hits[p].slots;
        end
    end

    always_comb begin
        for (int p = 0; p < `RD_PORTS; p++) begin
            read_entry[p] = entries_q[hits[p].slot];
            read_valid[p] = hits[p].hit;
        end
    end

    // slide each survivor down by the number of removed slots below it
    always_comb begin
        vcache_pkg::vic_cnt_t gap;
        gap       = '0;
        surv_cnt  = '0;
        survivors = '0;
        for (int s = 0; s < `VIC_SIZE; s++) begin
            if (s < int'(tail_q) && !remove_mask[s]) begin
                survivors[s - int'(gap)] = entries_q[s];
                surv_cnt = surv_cnt + 1'b1;
            end
            gap = gap + vcache_pkg::vic_cnt_t'(remove_mask[s]);
        end
    end

    always_comb begin
        fill_cnt = '0;
        for (int k = 0; k < `WR_PORTS; k++) begin
            fill_cnt = fill_cnt + vcache_pkg::vic_cnt_t'(fills[k].valid);
        end
    end

    // room is counted after removal, so a hit can make space for a fill
    always_comb begin
        free_cnt = vcache_pkg::vic_cnt_t'(`VIC_SIZE) - surv_cnt;
        if (fill_cnt > free_cnt) begin
            evict_cnt = fill_cnt - free_cnt;
        end else begin
            evict_cnt = '0;
        end
        keep_cnt = surv_cnt - evict_cnt;
    end

    // oldest survivors leave first, in age order
    always_comb begin
        for (int i = 0; i < `WR_PORTS; i++) begin
            evict_entry[i] = survivors[i];
            evict_valid[i] = (i < int'(evict_cnt));
        end
    end

    always_comb begin
        int pos;
        entries_d = '0;
        for (int j = 0; j < `VIC_SIZE; j++) begin
            if (j < int'(keep_cnt)) begin
                entries_d[j] = survivors[j + int'(evict_cnt)];
            end
        end
        // fills go behind the kept lines in port order
        pos = int'(keep_cnt);
        for (int k = 0; k < `WR_PORTS; k++) begin
            if (fills[k].valid) begin
                entries_d[pos].line       = fills[k].line;
                // anything below the tail is a live line
                entries_d[pos].line.valid = 1'b1;
                entries_d[pos].set_idx    = fills[k].set_idx;
                pos = pos + 1;
            end
        end
        tail_d = keep_cnt + fill_cnt;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entries_q <= '0;
            tail_q    <= '0;
        end else begin
            entries_q <= entries_d;
            tail_q    <= tail_d;
        end
    end

endmodule

/* src/victim_cache_top.sv */
`timescale 1ns/10ps

`include "vcache_settings.svh"

module victim_cache_top (
    input  logic                                   clock,
    input  logic                                   reset,
    input  vcache_pkg::vic_probe_t [`RD_PORTS-1:0] probes,
    input  vcache_pkg::vic_fill_t  [`WR_PORTS-1:0] fills,
    output vcache_pkg::vic_entry_t [`RD_PORTS-1:0] read_entry,
    output logic                   [`RD_PORTS-1:0] read_valid,
    output vcache_pkg::vic_entry_t [`WR_PORTS-1:0] evict_entry,
    output logic                   [`WR_PORTS-1:0] evict_valid
);

    // stored lines go to the lookup, hits come back the same cycle
    vcache_pkg::vic_entry_t [`VIC_SIZE-1:0] entries;
    vcache_pkg::vic_hit_t   [`RD_PORTS-1:0] hits;

    victim_lookup lookup_i (
        .entries (entries),
        .probes  (probes),
        .hits    (hits)
    );

    victim_queue queue_i (
        .clock       (clock),
        .reset       (reset),
        .hits        (hits),
        .fills       (fills),
        .entries     (entries),
        .read_entry  (read_entry),
        .read_valid  (read_valid),
        .evict_entry (evict_entry),
        .evict_valid (evict_valid)
    );

endmodule

/* bench/victim_cache_chk.sv */
`timescale 1ns/10ps

`include "vcache_settings.svh"

module victim_cache_chk (
    input  logic                                  clock,
    input  logic                                  reset,
    input  vcache_pkg::vic_cnt_t                  tail,
    input  vcache_pkg::vic_hit_t  [`RD_PORTS-1:0] hits,
    input  vcache_pkg::vic_fill_t [`WR_PORTS-1:0] fills,
    input  logic                  [`RD_PORTS-1:0] read_valid,
    input  logic                  [`WR_PORTS-1:0] evict_valid
);

    logic [`WR_PORTS-1:0] fill_valid;
    // enabled probe that landed on a live slot
    logic [`RD_PORTS-1:0] hit_live;

    always_comb begin
        for (int k = 0; k < `WR_PORTS; k++) begin
            fill_valid[k] = fills[k].valid;
        end
        for (int p = 0; p < `RD_PORTS; p++) begin
            hit_live[p] = hits[p].hit && (hits[p].slots != '0)
                       && (vcache_pkg::vic_cnt_t'(hits[p].slot) < tail);
        end
    end

    tail_in_range: assert property (@(posedge clock) tail <= `VIC_SIZE)
        else $error("tail count is above the buffer depth");

    evict_needs_fill: assert property (@(posedge clock) disable iff (reset)
        (|evict_valid) |-> (|fill_valid))
        else $error("eviction without any valid fill");

    read_needs_probe: assert property (@(posedge clock) disable iff (reset)
        (read_valid & ~hit_live) == '0)
        else $error("read valid without an enabled probe on a live slot");

    quiet_in_reset: assert property (@(posedge clock)
        reset |-> (read_valid == '0) && (evict_valid == '0))
        else $error("outputs valid during reset");

endmodule

bind victim_queue victim_cache_chk chk_i (
    .clock       (clock),
    .reset       (reset),
    .tail        (tail_q),
    .hits        (hits),
    .fills       (fills),
    .read_valid  (read_valid),
    .evict_valid (evict_valid)
);

/* bench/victim_cache_tb.sv */
`timescale 1ns/10ps

`include "vcache_settings.svh"

module victim_cache_tb;

    // tests need under 200 cycles
    localparam int MAX_CYCLES = 1000;

    logic clock = 1'b0;
    logic reset;
    vcache_pkg::vic_probe_t [`RD_PORTS-1:0] probes;
    vcache_pkg::vic_fill_t  [`WR_PORTS-1:0] fills;
    vcache_pkg::vic_entry_t [`RD_PORTS-1:0] read_entry;
    logic                   [`RD_PORTS-1:0] read_valid;
    vcache_pkg::vic_entry_t [`WR_PORTS-1:0] evict_entry;
    logic                   [`WR_PORTS-1:0] evict_valid;

    // reference queue, oldest first
    vcache_pkg::vic_entry_t model[$];
    integer seed = 32'hd4db5f07;
    int cycles = 0;

    victim_cache_top victim_cache_top_i (
        .clock       (clock),
        .reset       (reset),
        .probes      (probes),
        .fills       (fills),
        .read_entry  (read_entry),
        .read_valid  (read_valid),
        .evict_entry (evict_entry),
        .evict_valid (evict_valid)
    );

    always #2 clock = ~clock;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            abort_run("timeout: tests did not finish within the cycle limit");
        end
    end

    task automatic check_entry(input string name, input vcache_pkg::vic_entry_t exp,
                               input vcache_pkg::vic_entry_t act);
        if (exp !== act) begin
            abort_run($sformatf("mismatch in %s: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            abort_run($sformatf("mismatch in %s: expected %b actual %b", name, exp, act));
        end
    endtask

    function automatic logic key_match(input vcache_pkg::vic_probe_t pr,
                                       input vcache_pkg::vic_entry_t e);
        return pr.en && e.line.valid && (e.line.tag == pr.tag) && (e.set_idx == pr.set_idx);
    endfunction

    task automatic set_probe(input int p, input int set_idx, input int tag);
        probes[p].en      = 1'b1;
        probes[p].set_idx = set_idx[`SET_BITS-1:0];
        probes[p].tag     = tag[`TAG_BITS-1:0];
    endtask

    task automatic set_fill(input int k, input int set_idx, input int tag);
        fills[k].valid      = 1'b1;
        fills[k].set_idx    = set_idx[`SET_BITS-1:0];
        fills[k].line.valid = 1'b1;
        fills[k].line.tag   = tag[`TAG_BITS-1:0];
        fills[k].line.data  = {$random(seed), $random(seed)};
    endtask

    // checks this cycle's outputs against the model, then advances it
    task automatic step(input string name);
        vcache_pkg::vic_entry_t survivors[$];
        vcache_pkg::vic_entry_t added;
        logic [`VIC_SIZE-1:0]   removed;
        int found;
        int nfill;
        int evict;
        removed = '0;
        nfill   = 0;
        #1;
        for (int p = 0; p < `RD_PORTS; p++) begin
            found = -1;
            for (int i = model.size() - 1; i >= 0; i--) begin
                if (key_match(probes[p], model[i])) begin
                    found = i;
                end
            end
            check_flag($sformatf("%s read_valid[%0d]", name, p), found >= 0, read_valid[p]);
            if (found >= 0) begin
                check_entry($sformatf("%s read_entry[%0d]", name, p), model[found],
                            read_entry[p]);
                removed[found] = 1'b1;
            end
        end
        for (int i = 0; i < model.size(); i++) begin
            if (!removed[i]) begin
                survivors.push_back(model[i]);
            end
        end
        for (int k = 0; k < `WR_PORTS; k++) begin
            if (fills[k].valid) begin
                nfill++;
            end
        end
        evict = nfill - (`VIC_SIZE - survivors.size());
        if (evict < 0) begin
            evict = 0;
        end
        for (int i = 0; i < `WR_PORTS; i++) begin
            check_flag($sformatf("%s evict_valid[%0d]", name, i), i < evict, evict_valid[i]);
            if (i < evict) begin
                check_entry($sformatf("%s evict_entry[%0d]", name, i), survivors[i],
                            evict_entry[i]);
            end
        end
        for (int i = 0; i < evict; i++) begin
            void'(survivors.pop_front());
        end
        for (int k = 0; k < `WR_PORTS; k++) begin
            if (fills[k].valid) begin
                added.line       = fills[k].line;
                added.line.valid = 1'b1;
                added.set_idx    = fills[k].set_idx;
                survivors.push_back(added);
            end
        end
        model = survivors;
        @(negedge clock);
        probes = '0;
        fills  = '0;
    endtask

    task automatic test_reset_idle();
        set_probe(0, 1, 'h11);
        set_probe(1, 2, 'h22);
        step("test_reset_idle");
        set_probe(0, 0, 'h00);
        set_probe(1, 31, 'hff);
        step("test_reset_idle");
    endtask

    task automatic test_fill_then_hit();
        set_fill(0, 3, 'ha1);
        set_fill(1, 4, 'ha2);
        step("test_fill_then_hit");
        set_probe(0, 3, 'ha1);
        step("test_fill_then_hit");
        // first line is gone, second still hits
        set_probe(0, 3, 'ha1);
        set_probe(1, 4, 'ha2);
        step("test_fill_then_hit");
    endtask

    task automatic test_overflow_order();
        set_fill(0, 1, 'hb0);
        set_fill(1, 1, 'hb1);
        step("test_overflow_order");
        set_fill(0, 2, 'hb2);
        set_fill(1, 2, 'hb3);
        step("test_overflow_order");
        set_fill(0, 3, 'hb4);
        set_fill(1, 3, 'hb5);
        step("test_overflow_order");
        set_probe(0, 3, 'hb4);
        set_probe(1, 1, 'hb0);
        step("test_overflow_order");
        set_probe(0, 3, 'hb5);
        set_probe(1, 1, 'hb1);
        step("test_overflow_order");
    endtask

    task automatic test_compaction();
        set_fill(0, 5, 'hc0);
        set_fill(1, 6, 'hc1);
        step("test_compaction");
        // second oldest leaves, then two fills force one eviction
        set_probe(0, 2, 'hb3);
        step("test_compaction");
        set_fill(0, 7, 'hc2);
        set_fill(1, 8, 'hc3);
        step("test_compaction");
    endtask

    task automatic test_dual_probe();
        set_probe(0, 5, 'hc0);
        set_probe(1, 7, 'hc2);
        step("test_dual_probe");
        set_probe(0, 6, 'hc1);
        set_probe(1, 6, 'hc1);
        step("test_dual_probe");
        set_probe(0, 9, 'hee);
        step("test_dual_probe");
    endtask

    task automatic test_hit_frees_room();
        set_fill(0, 10, 'hd0);
        set_fill(1, 11, 'hd1);
        step("test_hit_frees_room");
        set_fill(0, 12, 'hd2);
        step("test_hit_frees_room");
        set_probe(0, 10, 'hd0);
        set_fill(0, 13, 'hd3);
        step("test_hit_frees_room");
        set_probe(0, 13, 'hd3);
        set_probe(1, 8, 'hc3);
        step("test_hit_frees_room");
    endtask

    initial begin
        reset  = 1'b1;
        probes = '0;
        fills  = '0;
        // fills and probes while in reset must leave no trace
        @(negedge clock);
        set_fill(0, 1, 'h11);
        set_fill(1, 2, 'h22);
        set_probe(0, 1, 'h11);
        set_probe(1, 2, 'h22);
        repeat (15) @(posedge clock);
        @(negedge clock);
        reset  = 1'b0;
        probes = '0;
        fills  = '0;
        test_reset_idle();
        test_fill_then_hit();
        test_overflow_order();
        test_compaction();
        test_dual_probe();
        test_hit_frees_room();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
src/vcache_pkg.sv
src/victim_lookup.sv
src/victim_queue.sv
src/victim_cache_top.sv
bench/victim_cache_chk.sv
bench/victim_cache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the victim cache testbench with Verilator, run it, then scan the log
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module victim_cache_tb -o victim_cache_sim || { echo "build failed"; exit 1; }
./obj_dir/victim_cache_sim > sim.log 2>&1
status=$?
cat sim.log
grep -q "TESTS FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
[ "$status" -eq 0 ] || { echo "simulator exited with status $status"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "no pass line in sim.log"; exit 1; }
exit 0
